// ==== run_sim.sh ====
#!/bin/sh
# builds the endpoint testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module tb_fpga_core -o tb_fpga_core
./obj_dir/tb_fpga_core | tee sim.log
if grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// ==== source/bar_regfile.sv ====
// BAR0 register stage that applies writes and reads back dwords for completion
`default_nettype none

`include "pcie_cfg.svh"

module bar_regfile (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire pcie_pkg::dec_req_t dec_req,
    input  wire                  dec_valid,
    output logic                 dec_ready,
    output pcie_pkg::rsp_t       rsp,
    output logic                 rsp_valid,
    input  wire                  rsp_ready
);

    import pcie_pkg::*;

    logic [`PCIE_DATA_WIDTH-1:0] regs [`PCIE_REG_COUNT];
    logic                        take;

    // same slot rule as the other stages, ready looks only at the stage below
    assign dec_ready = !rsp_valid || rsp_ready;
    assign take      = dec_valid && dec_ready;

    // writes land in the array on the edge that moves the item into the response slot
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            for (int i = 0; i < `PCIE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (dec_ready) begin
                rsp_valid <= dec_valid;
            end
            if (take && (dec_req.kind == MEM_WR)) begin
                // merge only the bytes enabled by first_be
                for (int b = 0; b < `PCIE_DATA_WIDTH / 8; b++) begin
                    if (dec_req.first_be[b]) begin
                        regs[dec_req.reg_idx][8*b +: 8] <= dec_req.wr_data[8*b +: 8];
                    end
                end
            end
        end
    end

    // response payload, reads see every write that was accepted before them
    always_ff @(posedge clk) begin
        if (take) begin
            rsp.requester_id <= dec_req.requester_id;
            rsp.tag          <= dec_req.tag;
            rsp.lower_addr   <= dec_req.addr_lo;
            case (dec_req.kind)
                MEM_RD: begin
                    rsp.cpl_needed <= 1'b1;
                    rsp.status     <= CPL_SC;
                    rsp.rd_data    <= regs[dec_req.reg_idx];
                end
                BAD_RD: begin
                    rsp.cpl_needed <= 1'b1;
                    rsp.status     <= CPL_UR;
                    rsp.rd_data    <= '0;
                end
                default: begin
                    // posted writes, good or bad, never get a completion
                    rsp.cpl_needed <= 1'b0;
                    rsp.status     <= CPL_SC;
                    rsp.rd_data    <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/cpl_build.sv ====
// completion builder that formats completion TLPs and drives the transmit stream
`default_nettype none

`include "pcie_cfg.svh"

module cpl_build (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire pcie_pkg::rsp_t         rsp,
    input  wire                         rsp_valid,
    output logic                        rsp_ready,
    input  wire [15:0]                  tl_cfg_ctl,
    input  wire [4:0]                   tl_cfg_add,
    input  wire [2:0]                   tl_cfg_func,
    output logic [`PCIE_DATA_WIDTH-1:0] tx_st_data,
    output pcie_pkg::tlp_hdr_u          tx_st_hdr,
    output logic                        tx_st_sop,
    output logic                        tx_st_eop,
    output logic                        tx_st_valid,
    output logic                        tx_st_err,
    input  wire                         tx_st_ready
);

    import pcie_pkg::*;

    logic [15:0] completer_id;
    tlp_hdr_u    cpl_hdr;
    logic        load;

    // bus and device come from the config bus, function is always 0 here
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            completer_id <= '0;
        end else if ((tl_cfg_add == `PCIE_CFG_BUSDEV_ADDR) && (tl_cfg_func == 3'd0)) begin
            completer_id <= {tl_cfg_ctl[7:0], tl_cfg_ctl[12:8], 3'b000};
        end
    end

    // the transmit slot drains on tx_st_ready, so the held beat stays stable until then
    assign rsp_ready = !tx_st_valid || tx_st_ready;
    assign load      = rsp_valid && rsp_ready && rsp.cpl_needed;

    // completion header written through the completion view of the union
    always_comb begin
        cpl_hdr                  = '0;
        cpl_hdr.cpl.completer_id = completer_id;
        cpl_hdr.cpl.status       = rsp.status;
        cpl_hdr.cpl.byte_count   = 12'd4;
        cpl_hdr.cpl.requester_id = rsp.requester_id;
        cpl_hdr.cpl.tag          = rsp.tag;
        cpl_hdr.cpl.lower_addr   = rsp.lower_addr;
        if (rsp.status == CPL_SC) begin
            {cpl_hdr.cpl.dw0.fmt, cpl_hdr.cpl.dw0.tlp_type} = FT_CPLD;
            cpl_hdr.cpl.dw0.length = 10'd1;
        end else begin
            // UR carries no data
            {cpl_hdr.cpl.dw0.fmt, cpl_hdr.cpl.dw0.tlp_type} = FT_CPL;
            cpl_hdr.cpl.dw0.length = 10'd0;
        end
    end

    // items without a completion are consumed here and leave an empty slot
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_st_valid <= 1'b0;
        end else if (rsp_ready) begin
            tx_st_valid <= rsp_valid && rsp.cpl_needed;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            tx_st_hdr  <= cpl_hdr;
            tx_st_data <= rsp.rd_data;
        end
    end

    // every completion fits in one beat
    assign tx_st_sop = tx_st_valid;
    assign tx_st_eop = tx_st_valid;
    assign tx_st_err = 1'b0;

endmodule

`default_nettype wire

// ==== source/fpga_core.sv ====
// endpoint top level chaining request decode, BAR0 access and completion build
`default_nettype none

`include "pcie_cfg.svh"

module fpga_core (
    input  wire                         clk,
    input  wire                         rst_n,

    // P-Tile receive stream, one whole TLP per beat
    input  wire [`PCIE_DATA_WIDTH-1:0]  rx_st_data,
    input  wire                         rx_st_empty,
    input  wire                         rx_st_sop,
    input  wire                         rx_st_eop,
    input  wire                         rx_st_valid,
    output logic                        rx_st_ready,
    input  wire [`PCIE_HDR_WIDTH-1:0]   rx_st_hdr,
    input  wire [2:0]                   rx_st_bar_range,

    // P-Tile transmit stream
    output logic [`PCIE_DATA_WIDTH-1:0] tx_st_data,
    output logic                        tx_st_sop,
    output logic                        tx_st_eop,
    output logic                        tx_st_valid,
    input  wire                         tx_st_ready,
    output logic                        tx_st_err,
    output logic [`PCIE_HDR_WIDTH-1:0]  tx_st_hdr,

    // configuration bus from the hard IP
    input  wire [15:0]                  tl_cfg_ctl,
    input  wire [4:0]                   tl_cfg_add,
    input  wire [2:0]                   tl_cfg_func
);

    import pcie_pkg::*;

    // a single-dword beat has no empty lanes, so rx_st_empty carries nothing useful
    dec_req_t dec_req;
    logic     dec_valid;
    logic     dec_ready;
    rsp_t     rsp;
    logic     rsp_valid;
    logic     rsp_ready;

    tlp_rx_decode i_decode (
        .clk             (clk),
        .rst_n           (rst_n),
        .rx_st_data      (rx_st_data),
        .rx_st_hdr       (rx_st_hdr),
        .rx_st_sop       (rx_st_sop),
        .rx_st_eop       (rx_st_eop),
        .rx_st_valid     (rx_st_valid),
        .rx_st_bar_range (rx_st_bar_range),
        .rx_st_ready     (rx_st_ready),
        .dec_req         (dec_req),
        .dec_valid       (dec_valid),
        .dec_ready       (dec_ready)
    );

    bar_regfile i_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_req   (dec_req),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    cpl_build i_cpl (
        .clk         (clk),
        .rst_n       (rst_n),
        .rsp         (rsp),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .tl_cfg_ctl  (tl_cfg_ctl),
        .tl_cfg_add  (tl_cfg_add),
        .tl_cfg_func (tl_cfg_func),
        .tx_st_data  (tx_st_data),
        .tx_st_hdr   (tx_st_hdr),
        .tx_st_sop   (tx_st_sop),
        .tx_st_eop   (tx_st_eop),
        .tx_st_valid (tx_st_valid),
        .tx_st_err   (tx_st_err),
        .tx_st_ready (tx_st_ready)
    );

endmodule

`default_nettype wire

// ==== source/pcie_cfg.svh ====
// pcie endpoint configuration macros shared by the package and the pipeline stages
`ifndef PCIE_CFG_SVH
`define PCIE_CFG_SVH

// width of the payload word carried with each beat
`define PCIE_DATA_WIDTH 32

// a request or completion header is four dwords
`define PCIE_HDR_WIDTH 128

// BAR0 is a flat array of dword registers
// the register index comes from address bits 9:2 and higher bits are ignored
`define PCIE_REG_COUNT 256

// only requests that the hard IP routes to this BAR are served
`define PCIE_BAR_NUM 3'd0

// tl_cfg_add value where tl_cfg_ctl carries the captured bus and device number
// tl_cfg_ctl[7:0] holds the bus number and tl_cfg_ctl[12:8] the device number
`define PCIE_CFG_BUSDEV_ADDR 5'h02

`endif

// ==== source/pcie_pkg.sv ====
// PCIe TLP field types, header views and pipeline stage payloads
`default_nettype none

`include "pcie_cfg.svh"

package pcie_pkg;

    // width of a register index, address bits 9:2 for 256 registers
    localparam int REG_IDX_W = $clog2(`PCIE_REG_COUNT);

    // combined {fmt, type} codes for the TLPs this endpoint handles
    localparam logic [7:0] FT_MRD32 = 8'h00;
    localparam logic [7:0] FT_MWR32 = 8'h40;
    localparam logic [7:0] FT_CPL   = 8'h0a;
    localparam logic [7:0] FT_CPLD  = 8'h4a;

    // completion status codes
    localparam logic [2:0] CPL_SC = 3'b000;
    localparam logic [2:0] CPL_UR = 3'b001;

    // first dword common to all headers, dw0 sits in the upper bits of the header
    typedef struct packed {
        logic [2:0]  fmt;
        logic [4:0]  tlp_type;
        logic [13:0] rsvd;
        logic [9:0]  length;
    } tlp_dw0_t;

    // memory request header with a 32-bit address
    typedef struct packed {
        tlp_dw0_t    dw0;
        logic [15:0] requester_id;
        logic [7:0]  tag;
        logic [3:0]  last_be;
        logic [3:0]  first_be;
        logic [31:0] addr;
        logic [31:0] rsvd_dw;
    } tlp_req_hdr_t;

    // completion header, the spare bit pads lower_addr out to a full dword
    typedef struct packed {
        tlp_dw0_t    dw0;
        logic [15:0] completer_id;
        logic [2:0]  status;
        logic        bcm;
        logic [11:0] byte_count;
        logic [15:0] requester_id;
        logic [7:0]  tag;
        logic        rsvd_la;
        logic [6:0]  lower_addr;
        logic [31:0] rsvd_dw;
    } tlp_cpl_hdr_t;

    // receive headers are read as requests, transmit headers are written as completions
    typedef union packed {
        tlp_req_hdr_t req;
        tlp_cpl_hdr_t cpl;
    } tlp_hdr_u;

    // request classes, bad ones are reads or writes that are not served
    typedef enum logic [1:0] {
        MEM_WR,
        MEM_RD,
        BAD_WR,
        BAD_RD
    } req_kind_e;

    // decoded request handed from the decode stage to the register stage
    typedef struct packed {
        req_kind_e                    kind;
        logic [REG_IDX_W-1:0]         reg_idx;
        logic [3:0]                   first_be;
        logic [`PCIE_DATA_WIDTH-1:0]  wr_data;
        logic [15:0]                  requester_id;
        logic [7:0]                   tag;
        logic [6:0]                   addr_lo;
    } dec_req_t;

    // result of the register stage handed to the completion builder
    typedef struct packed {
        logic                         cpl_needed;
        logic [2:0]                   status;
        logic [`PCIE_DATA_WIDTH-1:0]  rd_data;
        logic [15:0]                  requester_id;
        logic [7:0]                   tag;
        logic [6:0]                   lower_addr;
    } rsp_t;

endpackage

`default_nettype wire

// ==== source/tlp_rx_decode.sv ====
// receive stage that decodes request headers and classifies each TLP
`default_nettype none

`include "pcie_cfg.svh"

module tlp_rx_decode (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire [`PCIE_DATA_WIDTH-1:0]  rx_st_data,
    input  wire pcie_pkg::tlp_hdr_u     rx_st_hdr,
    input  wire                         rx_st_sop,
    input  wire                         rx_st_eop,
    input  wire                         rx_st_valid,
    input  wire [2:0]                   rx_st_bar_range,
    output logic                        rx_st_ready,
    output pcie_pkg::dec_req_t          dec_req,
    output logic                        dec_valid,
    input  wire                         dec_ready
);

    import pcie_pkg::*;

    tlp_req_hdr_t req;
    logic [7:0]   fmt_type;
    logic         is_rd;
    logic         is_wr;
    logic         well_formed;
    logic         run;
    logic         accept;
    req_kind_e    kind;

    // the receive header is always viewed as a memory request
    assign req      = rx_st_hdr.req;
    assign fmt_type = {req.dw0.fmt, req.dw0.tlp_type};
    assign is_rd    = (fmt_type == FT_MRD32);
    assign is_wr    = (fmt_type == FT_MWR32);

    // a served request is one dword, hits BAR0 and fits in a single beat
    assign well_formed = (req.dw0.length == 10'd1) &&
                         (rx_st_bar_range == `PCIE_BAR_NUM) &&
                         rx_st_sop && rx_st_eop;

    // fmt bit 1 marks a TLP with payload, so an unknown type with data counts as a write
    always_comb begin
        if (well_formed && is_wr) begin
            kind = MEM_WR;
        end else if (well_formed && is_rd) begin
            kind = MEM_RD;
        end else if (req.dw0.fmt[1]) begin
            kind = BAD_WR;
        end else begin
            kind = BAD_RD;
        end
    end

    // run stays low through reset so the stream is not accepted until reset is released
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    // take a new beat when the slot is empty or is being drained this cycle
    assign rx_st_ready = run && (!dec_valid || dec_ready);
    assign accept      = rx_st_valid && rx_st_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (rx_st_ready) begin
            dec_valid <= rx_st_valid;
        end
    end

    // payload slot, only loaded together with the valid bit
    always_ff @(posedge clk) begin
        if (accept) begin
            dec_req.kind         <= kind;
            dec_req.reg_idx      <= req.addr[REG_IDX_W+1:2];
            dec_req.first_be     <= req.first_be;
            dec_req.wr_data      <= rx_st_data;
            dec_req.requester_id <= req.requester_id;
            dec_req.tag          <= req.tag;
            dec_req.addr_lo      <= req.addr[6:0];
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+source
source/pcie_pkg.sv
source/tlp_rx_decode.sv
source/bar_regfile.sv
source/cpl_build.sv
source/fpga_core.sv
verif/fpga_core_properties.sv
verif/tb_fpga_core.sv

// ==== verif/fpga_core_properties.sv ====
// concurrent checks on the transmit stream handshake and beat framing of the endpoint
`default_nettype none

`include "pcie_cfg.svh"

module fpga_core_properties (
    input wire                        clk,
    input wire                        rst_n,
    input wire                        tx_st_valid,
    input wire                        tx_st_ready,
    input wire                        tx_st_sop,
    input wire                        tx_st_eop,
    input wire [`PCIE_HDR_WIDTH-1:0]  tx_st_hdr,
    input wire [`PCIE_DATA_WIDTH-1:0] tx_st_data
);

    timeunit 1ns;
    timeprecision 1ps;

    // a stalled beat keeps valid and its whole payload until ready is seen
    assert property (@(posedge clk) disable iff (!rst_n)
        (tx_st_valid && !tx_st_ready) |=>
            (tx_st_valid && $stable(tx_st_hdr) && $stable(tx_st_data)))
        else $error("transmit beat changed while it was stalled");

    // one edge in reset is enough to clear the transmit slot
    assert property (@(posedge clk) !rst_n |=> !tx_st_valid)
        else $error("tx_st_valid is high during reset");

    // every completion is a single beat
    assert property (@(posedge clk) disable iff (!rst_n)
        (tx_st_sop == tx_st_valid) && (tx_st_eop == tx_st_valid))
        else $error("tx_st_sop or tx_st_eop does not follow tx_st_valid");

endmodule

bind fpga_core fpga_core_properties i_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .tx_st_valid (tx_st_valid),
    .tx_st_ready (tx_st_ready),
    .tx_st_sop   (tx_st_sop),
    .tx_st_eop   (tx_st_eop),
    .tx_st_hdr   (tx_st_hdr),
    .tx_st_data  (tx_st_data)
);

`default_nettype wire

// ==== verif/tb_fpga_core.sv ====
// testbench for the endpoint core that issues memory requests and checks completions
`default_nettype none

`include "pcie_cfg.svh"

module tb_fpga_core;

    timeunit 1ns;
    timeprecision 1ps;

    import pcie_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int N_RAND     = 24;
    localparam int N_BE       = 16;
    localparam int N_BURST    = 40;
    // config test issues two requests and the unsupported test seven
    localparam int N_REQ      = 2 + 2 * N_RAND + 3 * N_BE + 7 + N_BURST;

    // one request beat as it goes out on the receive stream
    typedef struct packed {
        tlp_hdr_u    hdr;
        logic [31:0] data;
        logic [2:0]  bar;
    } stim_t;

    // expected transmit beat where cpl is low for posted requests
    typedef struct packed {
        logic        cpl;
        tlp_hdr_u    hdr;
        logic [31:0] data;
    } exp_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] rx_st_data;
    logic        rx_st_empty;
    logic        rx_st_sop;
    logic        rx_st_eop;
    logic        rx_st_valid;
    logic        rx_st_ready;
    tlp_hdr_u    rx_st_hdr;
    logic [2:0]  rx_st_bar_range;
    logic [31:0] tx_st_data;
    logic        tx_st_sop;
    logic        tx_st_eop;
    logic        tx_st_valid;
    logic        tx_st_ready = 1'b1;
    logic        tx_st_err;
    tlp_hdr_u    tx_st_hdr;
    logic [15:0] tl_cfg_ctl;
    logic [4:0]  tl_cfg_add;
    logic [2:0]  tl_cfg_func;

    logic [31:0] model [256];
    exp_t        exp_q [$];
    logic [15:0] cid_exp = 16'h0000;
    bit          bp_en = 1'b0;
    int          checks = 0;
    int          errors = 0;

    fpga_core i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // expected completion for one request while the model array takes every served write
    function automatic exp_t ref_model(input stim_t s, input logic [15:0] cid,
                                       ref logic [31:0] mem [256]);
        exp_t         e;
        tlp_req_hdr_t r;
        logic [7:0]   idx;
        logic         in_bar;
        r      = s.hdr.req;
        idx    = r.addr[9:2];
        in_bar = (r.dw0.length == 10'd1) && (s.bar == `PCIE_BAR_NUM);
        e      = '0;
        if (r.dw0.fmt[1]) begin
            // a bad posted request is dropped without a trace
            if (in_bar && ({r.dw0.fmt, r.dw0.tlp_type} == FT_MWR32)) begin
                for (int b = 0; b < 4; b++) begin
                    if (r.first_be[b]) begin
                        mem[idx][8*b +: 8] = s.data[8*b +: 8];
                    end
                end
            end
        end else begin
            e.cpl                  = 1'b1;
            e.hdr.cpl.completer_id = cid;
            e.hdr.cpl.byte_count   = 12'd4;
            e.hdr.cpl.requester_id = r.requester_id;
            e.hdr.cpl.tag          = r.tag;
            e.hdr.cpl.lower_addr   = r.addr[6:0];
            if (in_bar && ({r.dw0.fmt, r.dw0.tlp_type} == FT_MRD32)) begin
                {e.hdr.cpl.dw0.fmt, e.hdr.cpl.dw0.tlp_type} = FT_CPLD;
                e.hdr.cpl.dw0.length = 10'd1;
                e.hdr.cpl.status     = CPL_SC;
                e.data               = mem[idx];
            end else begin
                {e.hdr.cpl.dw0.fmt, e.hdr.cpl.dw0.tlp_type} = FT_CPL;
                e.hdr.cpl.status = CPL_UR;
            end
        end
        return e;
    endfunction

    // request with random requester_id, tag and payload
    function automatic stim_t make_req(input logic [7:0] ft, input logic [31:0] addr,
                                       input logic [3:0] be, input logic [9:0] len,
                                       input logic [2:0] bar);
        stim_t       s;
        logic [31:0] r;
        r = $urandom();
        s = '0;
        {s.hdr.req.dw0.fmt, s.hdr.req.dw0.tlp_type} = ft;
        s.hdr.req.dw0.length   = len;
        s.hdr.req.requester_id = r[15:0];
        s.hdr.req.tag          = r[23:16];
        s.hdr.req.first_be     = be;
        s.hdr.req.addr         = {addr[31:2], 2'b00};
        s.data                 = $urandom();
        s.bar                  = bar;
        return s;
    endfunction

    // drives one beat and holds it until the decode stage takes it
    task automatic send(input stim_t s);
        exp_t e;
        logic accepted;
        e = ref_model(s, cid_exp, model);
        if (e.cpl) begin
            exp_q.push_back(e);
        end
        rx_st_hdr       = s.hdr;
        rx_st_data      = s.data;
        rx_st_bar_range = s.bar;
        rx_st_sop       = 1'b1;
        rx_st_eop       = 1'b1;
        rx_st_valid     = 1'b1;
        accepted        = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = rx_st_ready;
            @(posedge clk);
            #1;
        end
        rx_st_valid = 1'b0;
    endtask

    // waits for the queue to empty and then reports the test
    task automatic finish_test(input string name, input int err_before);
        for (int i = 0; (i < 400) && (exp_q.size() > 0); i++) begin
            @(posedge clk);
        end
        #1;
        assert (exp_q.size() == 0) else begin
            $display("%0d completions never arrived in test %s", exp_q.size(), name);
            errors++;
        end
        $display("test %s done with %0d errors", name, errors - err_before);
    endtask

    // ready is random only while a back-pressure test runs
    always @(posedge clk) begin
        logic [31:0] r;
        #1;
        r = $urandom();
        tx_st_ready = bp_en ? r[0] : 1'b1;
    end

    // outputs are sampled half a cycle after the drive point and a transfer happens on the next edge
    always @(negedge clk) begin
        exp_t e;
        if (rst_n && tx_st_valid && tx_st_ready) begin
            checks++;
            assert (exp_q.size() > 0) else begin
                $display("a completion came out at %0t although none was expected", $time);
                errors++;
            end
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                assert ((tx_st_hdr == e.hdr) && !tx_st_err) else begin
                    $display("Fail %0t: header %h err %b, expected %h", $time, tx_st_hdr,
                             tx_st_err, e.hdr);
                    errors++;
                end
                if (e.hdr.cpl.dw0.length != 10'd0) begin
                    assert (tx_st_data == e.data) else begin
                        $display("Fail %0t: data %h, expected %h", $time, tx_st_data, e.data);
                        errors++;
                    end
                end
            end
        end
    end

    // the run cannot outlast 40 cycles per request plus a margin
    initial begin
        #(N_REQ * 40 * CLK_PERIOD + 2000);
        $display("timeout: the run did not finish in the allowed time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        logic [31:0] a;
        logic [31:0] r;
        logic [31:0] wr_addr [N_RAND];
        int          base;
        void'($urandom(32'hbd0c_ad6e));
        rst_n           = 1'b0;
        rx_st_data      = '0;
        rx_st_empty     = 1'b0;
        rx_st_sop       = 1'b0;
        rx_st_eop       = 1'b0;
        rx_st_valid     = 1'b0;
        rx_st_hdr       = '0;
        rx_st_bar_range = '0;
        tl_cfg_ctl      = '0;
        tl_cfg_add      = 5'h1f;
        tl_cfg_func     = '0;
        for (int i = 0; i < 256; i++) begin
            model[i] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // bus 0x5a and device 0x13 on the config bus
        base        = errors;
        tl_cfg_ctl  = {3'b000, 5'h13, 8'h5a};
        tl_cfg_add  = `PCIE_CFG_BUSDEV_ADDR;
        cid_exp     = {8'h5a, 5'h13, 3'b000};
        repeat (2) @(posedge clk);
        #1;
        tl_cfg_add  = 5'h00;
        a = $urandom();
        send(make_req(FT_MWR32, a, 4'hf, 10'd1, 3'd0));
        send(make_req(FT_MRD32, a, 4'hf, 10'd1, 3'd0));
        finish_test("config", base);

        // reads pick among the written registers so the data path carries real values
        base = errors;
        for (int i = 0; i < N_RAND; i++) begin
            a = $urandom();
            wr_addr[i] = a;
            send(make_req(FT_MWR32, a, 4'hf, 10'd1, 3'd0));
        end
        for (int i = 0; i < N_RAND; i++) begin
            a = wr_addr[$urandom_range(N_RAND - 1, 0)];
            send(make_req(FT_MRD32, a, 4'hf, 10'd1, 3'd0));
        end
        finish_test("random", base);

        // a full write first fills the register so the disabled bytes hold random data
        base = errors;
        for (int i = 0; i < N_BE; i++) begin
            a = $urandom();
            send(make_req(FT_MWR32, a, 4'hf, 10'd1, 3'd0));
            r = $urandom();
            send(make_req(FT_MWR32, a, r[3:0], 10'd1, 3'd0));
            send(make_req(FT_MRD32, a, 4'hf, 10'd1, 3'd0));
        end
        finish_test("byte_enable", base);

        // every bad request aims at one register that is read back at the end
        base = errors;
        a = $urandom();
        send(make_req(FT_MRD32, a, 4'hf, 10'd1, 3'd1));
        send(make_req(FT_MWR32, a, 4'hf, 10'd1, 3'd1));
        send(make_req(FT_MRD32, a, 4'hf, 10'd2, 3'd0));
        send(make_req(FT_MWR32, a, 4'hf, 10'd2, 3'd0));
        send(make_req(8'h1b, a, 4'hf, 10'd1, 3'd0));
        send(make_req(8'h5b, a, 4'hf, 10'd1, 3'd0));
        send(make_req(FT_MRD32, a, 4'hf, 10'd1, 3'd0));
        finish_test("unsupported", base);

        base  = errors;
        bp_en = 1'b1;
        for (int i = 0; i < N_BURST; i++) begin
            a = $urandom();
            send(make_req(FT_MRD32, a, 4'hf, 10'd1, 3'd0));
        end
        finish_test("backpressure", base);
        bp_en = 1'b0;

        $display("%0d completions checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
